// File: source/aluPkg.sv
`default_nettype none

package aluPkg;

  localparam int wordWidth   = 16;
  localparam int nibbleWidth = 4;
  localparam int byteWidth   = 8;
  localparam int shamtWidth  = 4;
  localparam int opWidth     = 4;

  typedef logic [wordWidth-1:0]   word_t;
  typedef logic [nibbleWidth-1:0] nibble_t;   // one lookahead block or PADDSB lane
  typedef logic [shamtWidth-1:0]  shamt_t;

  // opcode map of the teaching ISA, 1000 and up are unused
  typedef enum logic [opWidth-1:0] {
    opAdd    = 4'b0000,
    opSub    = 4'b0001,
    opXor    = 4'b0010,
    opRed    = 4'b0011,
    opSll    = 4'b0100,
    opSra    = 4'b0101,
    opRor    = 4'b0110,
    opPaddsb = 4'b0111
  } aluOp_t;

  // low two opcode bits of the shift group
  typedef enum logic [1:0] {
    modeSll = 2'b00,
    modeSra = 2'b01,
    modeRor = 2'b10
  } shiftMode_t;

  typedef struct packed {
    word_t a;
    word_t b;
  } operandPair_t;

  // saturation limits
  localparam word_t   satMax       = 16'h7FFF;
  localparam word_t   satMin       = 16'h8000;
  localparam nibble_t nibbleSatMax = 4'b0111;
  localparam nibble_t nibbleSatMin = 4'b1000;

endpackage

`default_nettype wire

// File: source/claAdder4.sv
`timescale 1ns/1ns
`default_nettype none

module claAdder4 (
  input  wire aluPkg::nibble_t a,
  input  wire aluPkg::nibble_t b,
  input  wire                  carryIn,
  output aluPkg::nibble_t      sum,
  output logic                 carryOut,
  output logic                 signedOverflow
);

  aluPkg::nibble_t              g;  // generate
  aluPkg::nibble_t              p;  // propagate, xor form so it doubles as half sum
  logic [aluPkg::nibbleWidth:0] c;  // c[i] is the carry into bit i

  assign g = a & b;
  assign p = a ^ b;

  // flattened lookahead terms, no ripple between bits
  assign c[0] = carryIn;
  assign c[1] = g[0] | (p[0] & carryIn);
  assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & carryIn);
  assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
              | (p[2] & p[1] & p[0] & carryIn);
  assign c[4] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
              | (p[3] & p[2] & p[1] & g[0])
              | (p[3] & p[2] & p[1] & p[0] & carryIn);

  assign sum      = p ^ c[aluPkg::nibbleWidth-1:0];
  assign carryOut = c[aluPkg::nibbleWidth];

  // carry into the sign bit disagrees with carry out
  assign signedOverflow = c[aluPkg::nibbleWidth-1] ^ c[aluPkg::nibbleWidth];

endmodule

`default_nettype wire

// File: source/satAddSub.sv
`timescale 1ns/1ns
`default_nettype none

module satAddSub (
  input  wire aluPkg::operandPair_t operands,
  input  wire                       subtract,
  output aluPkg::word_t             sum,
  output logic                      overflow
);

  localparam int msb = aluPkg::wordWidth - 1;

  aluPkg::word_t                     bMod;      // b or ~b
  aluPkg::word_t                     rawSum;    // wrapped result
  logic [3:0]                        carry;     // carries between the four blocks
  logic signed [aluPkg::wordWidth:0] exactSum;  // behavioral 17-bit result

  assign bMod     = operands.b ^ {aluPkg::wordWidth{subtract}};
  assign carry[0] = subtract;  // +1 of the two's complement

  claAdder4 i_cla0 (
    .a(operands.a[3:0]), .b(bMod[3:0]), .carryIn(carry[0]),
    .sum(rawSum[3:0]), .carryOut(carry[1]), .signedOverflow()
  );

  claAdder4 i_cla1 (
    .a(operands.a[7:4]), .b(bMod[7:4]), .carryIn(carry[1]),
    .sum(rawSum[7:4]), .carryOut(carry[2]), .signedOverflow()
  );

  claAdder4 i_cla2 (
    .a(operands.a[11:8]), .b(bMod[11:8]), .carryIn(carry[2]),
    .sum(rawSum[11:8]), .carryOut(carry[3]), .signedOverflow()
  );

  // only the top block sees the word's sign bit
  claAdder4 i_cla3 (
    .a(operands.a[15:12]), .b(bMod[15:12]), .carryIn(carry[3]),
    .sum(rawSum[15:12]), .carryOut(), .signedOverflow(overflow)
  );

  // on overflow a and bMod share a sign, which is the sign of the true result
  assign sum = overflow ? (operands.a[msb] ? aluPkg::satMin : aluPkg::satMax) : rawSum;

  assign exactSum = subtract ? ($signed(operands.a) - $signed(operands.b))
                             : ($signed(operands.a) + $signed(operands.b));

  // a limit value without the flag has to be a real in-range result
  always_comb begin
    if (!overflow && (sum == aluPkg::satMax || sum == aluPkg::satMin)) begin
      assert final (exactSum == {sum[msb], sum})
        else $error("satAddSub: limit value %h without overflow", sum);
    end
  end

endmodule

`default_nettype wire

// File: source/nibbleSatAdder.sv
`timescale 1ns/1ns
`default_nettype none

module nibbleSatAdder (
  input  wire aluPkg::operandPair_t operands,
  output aluPkg::word_t             sum,
  output logic                      overflow
);

  localparam int nw    = aluPkg::nibbleWidth;
  localparam int lanes = aluPkg::wordWidth / nw;

  aluPkg::word_t    rawSum;   // wrapped lane sums
  logic [lanes-1:0] laneOvf;

  // lanes are independent, carry never crosses a nibble boundary
  for (genvar i = 0; i < lanes; i++) begin : g_lane
    localparam int lo = i * nw;

    claAdder4 i_cla (
      .a(operands.a[lo +: nw]),
      .b(operands.b[lo +: nw]),
      .carryIn(1'b0),
      .sum(rawSum[lo +: nw]),
      .carryOut(),
      .signedOverflow(laneOvf[i])
    );

    // both inputs share a sign on overflow, so a's sign picks the limit
    assign sum[lo +: nw] = laneOvf[i]
        ? (operands.a[lo + nw - 1] ? aluPkg::nibbleSatMin : aluPkg::nibbleSatMax)
        : rawSum[lo +: nw];
  end

  assign overflow = |laneOvf;  // any lane clipped

endmodule

`default_nettype wire

// File: source/byteReducer.sv
`timescale 1ns/1ns
`default_nettype none

module byteReducer (
  input  wire aluPkg::operandPair_t operands,
  output aluPkg::word_t             sum
);

  localparam int nw = aluPkg::nibbleWidth;
  localparam int bw = aluPkg::byteWidth;

  logic [1:0][bw:0] partial;    // 9-bit signed sums, [0] low bytes, [1] high bytes
  logic [1:0]       midCarry;   // between the nibble blocks of one byte
  logic [1:0]       byteCarry;  // out of each byte
  logic             stage2Mid;
  logic             stage2Carry;
  logic             carry9;
  logic [bw+1:0]    total;      // 10-bit signed total

  // stage 1, a byte of a plus the same byte of b
  for (genvar i = 0; i < 2; i++) begin : g_byte
    localparam int lo = i * bw;

    claAdder4 i_claLo (
      .a(operands.a[lo +: nw]), .b(operands.b[lo +: nw]), .carryIn(1'b0),
      .sum(partial[i][nw-1:0]), .carryOut(midCarry[i]), .signedOverflow()
    );

    claAdder4 i_claHi (
      .a(operands.a[lo + nw +: nw]), .b(operands.b[lo + nw +: nw]),
      .carryIn(midCarry[i]),
      .sum(partial[i][bw-1:nw]), .carryOut(byteCarry[i]), .signedOverflow()
    );

    // ninth bit from the sign-extended byte operands
    assign partial[i][bw] = operands.a[lo + bw - 1] ^ operands.b[lo + bw - 1] ^ byteCarry[i];
  end

  // stage 2, low eight bits of the partials through two more blocks
  claAdder4 i_claSumLo (
    .a(partial[0][nw-1:0]), .b(partial[1][nw-1:0]), .carryIn(1'b0),
    .sum(total[nw-1:0]), .carryOut(stage2Mid), .signedOverflow()
  );

  claAdder4 i_claSumHi (
    .a(partial[0][bw-1:nw]), .b(partial[1][bw-1:nw]), .carryIn(stage2Mid),
    .sum(total[bw-1:nw]), .carryOut(stage2Carry), .signedOverflow()
  );

  // bit 8 plus one sign-extension bit, 10 bits always hold four bytes
  assign total[bw]   = partial[0][bw] ^ partial[1][bw] ^ stage2Carry;
  assign carry9      = (partial[0][bw] & partial[1][bw])
                     | (stage2Carry & (partial[0][bw] ^ partial[1][bw]));
  assign total[bw+1] = partial[0][bw] ^ partial[1][bw] ^ carry9;

  assign sum = {{(aluPkg::wordWidth - bw - 2){total[bw+1]}}, total};

endmodule

`default_nettype wire

// File: source/shifter.sv
`timescale 1ns/1ns
`default_nettype none

module shifter (
  input  wire aluPkg::word_t      data,
  input  wire aluPkg::shamt_t     shamt,
  input  wire aluPkg::shiftMode_t mode,
  output aluPkg::word_t           shifted
);

  aluPkg::word_t stage;  // running value through the log stages

  // log shifter, stage k moves by 2**k when shamt[k] is set
  always_comb begin
    stage = data;
    for (int k = 0; k < aluPkg::shamtWidth; k++) begin
      if (shamt[k]) begin
        case (mode)
          aluPkg::modeSll: begin
            stage = stage << (1 << k);  // zero fill
          end
          aluPkg::modeSra: begin
            stage = $signed(stage) >>> (1 << k);  // sign fill
          end
          aluPkg::modeRor: begin
            stage = (stage >> (1 << k)) | (stage << (aluPkg::wordWidth - (1 << k)));
          end
          default: begin
            stage = '0;  // mode 11 belongs to PADDSB
          end
        endcase
      end
    end
    shifted = stage;
  end

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  wire                       clk,
  input  wire                       rstN,
  input  wire aluPkg::operandPair_t operands,
  input  wire aluPkg::shamt_t       imm,
  input  wire aluPkg::aluOp_t       op,
  output aluPkg::word_t             result,
  output logic                      overflow
);

  aluPkg::word_t      addSubSum;
  aluPkg::word_t      nibbleSum;
  aluPkg::word_t      reduceSum;
  aluPkg::word_t      shiftOut;
  aluPkg::word_t      nextResult;
  logic               addSubOvf;
  logic               nibbleOvf;
  logic               nextOverflow;
  aluPkg::shiftMode_t shiftMode;

  assign shiftMode = aluPkg::shiftMode_t'(op[1:0]);

  satAddSub i_satAddSub (
    .operands(operands),
    .subtract(op[0]),  // ADD 0000, SUB 0001
    .sum(addSubSum),
    .overflow(addSubOvf)
  );

  nibbleSatAdder i_nibbleSatAdder (
    .operands(operands),
    .sum(nibbleSum),
    .overflow(nibbleOvf)
  );

  byteReducer i_byteReducer (
    .operands(operands),
    .sum(reduceSum)
  );

  shifter i_shifter (
    .data(operands.a),
    .shamt(imm),
    .mode(shiftMode),
    .shifted(shiftOut)
  );

  always_comb begin
    nextResult   = '0;
    nextOverflow = 1'b0;
    case (op)
      aluPkg::opAdd, aluPkg::opSub: begin
        nextResult   = addSubSum;
        nextOverflow = addSubOvf;
      end
      aluPkg::opXor:    nextResult = operands.a ^ operands.b;
      aluPkg::opRed:    nextResult = reduceSum;
      aluPkg::opSll, aluPkg::opSra, aluPkg::opRor: begin
        nextResult = shiftOut;
      end
      aluPkg::opPaddsb: begin
        nextResult   = nibbleSum;
        nextOverflow = nibbleOvf;
      end
      default: ;  // 1000 to 1111 leave zero and a clear flag
    endcase
  end

  // one register stage accepting a new op every cycle
  always_ff @(posedge clk) begin
    if (!rstN) begin
      result   <= '0;
      overflow <= 1'b0;
    end else begin
      result   <= nextResult;
      overflow <= nextOverflow;
    end
  end

  opKnown : assert property (@(posedge clk) rstN |-> !$isunknown(op))
    else $error("alu: opcode unknown out of reset");

endmodule

`default_nettype wire

// File: tests/aluTb.sv
`timescale 1ns/1ns
`default_nettype none

module aluTb;

  // expected register contents for one set of inputs
  typedef struct packed {
    aluPkg::word_t result;
    logic          overflow;
  } expected_t;

  logic                 clk;
  logic                 rstN;
  aluPkg::operandPair_t operands;
  aluPkg::shamt_t       imm;
  aluPkg::aluOp_t       op;
  aluPkg::word_t        result;
  logic                 overflow;

  expected_t   modelNow;       // model of the inputs the DUT sees at the next edge
  logic        historyValid;   // at least one edge seen, $past is meaningful
  logic        prevRstN;
  int unsigned checkedCycles;  // edges whose result was compared
  int unsigned issuedOps;

  alu i_alu (
    .clk(clk),
    .rstN(rstN),
    .operands(operands),
    .imm(imm),
    .op(op),
    .result(result),
    .overflow(overflow)
  );

  always #5 clk = ~clk;

  task automatic stopWithFailure();
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic reportMismatch(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    stopWithFailure();
  endtask

  // reference behavior, written from the instruction set rules
  function automatic expected_t referenceModel(input aluPkg::aluOp_t opIn,
                                               input aluPkg::operandPair_t ops,
                                               input aluPkg::shamt_t amount);
    expected_t e;
    int        sa;
    int        sb;
    int        exact;
    int        laneA;
    int        laneB;
    int        laneSum;
    int        src;
    e = '0;
    case (opIn)
      aluPkg::opAdd, aluPkg::opSub: begin
        sa = $signed(ops.a);
        sb = $signed(ops.b);
        exact = (opIn == aluPkg::opSub) ? sa - sb : sa + sb;
        if (exact > 32767) begin
          e.result   = 16'h7FFF;
          e.overflow = 1'b1;
        end else if (exact < -32768) begin
          e.result   = 16'h8000;
          e.overflow = 1'b1;
        end else begin
          e.result = exact[15:0];
        end
      end
      aluPkg::opXor: e.result = ops.a ^ ops.b;
      aluPkg::opRed: begin
        exact = 0;
        for (int i = 0; i < 2; i++) begin
          sa = $signed(ops.a[8*i +: 8]);
          sb = $signed(ops.b[8*i +: 8]);
          exact = exact + sa + sb;
        end
        e.result = exact[15:0];  // at most 10 significant bits
      end
      aluPkg::opSll: begin
        for (int i = 0; i < 16; i++) begin
          e.result[i] = (i >= amount) ? ops.a[i - amount] : 1'b0;
        end
      end
      aluPkg::opSra: begin
        for (int i = 0; i < 16; i++) begin
          src = i + amount;
          e.result[i] = (src > 15) ? ops.a[15] : ops.a[src];
        end
      end
      aluPkg::opRor: begin
        for (int i = 0; i < 16; i++) begin
          e.result[i] = ops.a[(i + amount) % 16];
        end
      end
      aluPkg::opPaddsb: begin
        for (int i = 0; i < 4; i++) begin
          laneA = $signed(ops.a[4*i +: 4]);
          laneB = $signed(ops.b[4*i +: 4]);
          laneSum = laneA + laneB;
          if (laneSum > 7) begin
            laneSum = 7;
            e.overflow = 1'b1;
          end else if (laneSum < -8) begin
            laneSum = -8;
            e.overflow = 1'b1;
          end
          e.result[4*i +: 4] = laneSum[3:0];
        end
      end
      default: e = '0;  // undefined opcodes
    endcase
    return e;
  endfunction

  always_comb modelNow = referenceModel(op, operands, imm);

  always @(posedge clk) begin
    historyValid <= 1'b1;
    prevRstN     <= rstN;
    if (prevRstN) begin
      checkedCycles <= checkedCycles + 1;
    end
  end

  // outputs cleared by every edge that saw reset low
  resetClears : assert property (@(posedge clk)
      historyValid && !$past(rstN) |-> (result == '0 && overflow == 1'b0))
    else reportMismatch($sformatf("after reset edge result %h overflow %b, expected zero",
                                  result, overflow));

  resultMatches : assert property (@(posedge clk)
      historyValid && $past(rstN) |-> result == $past(modelNow.result))
    else reportMismatch($sformatf("op %b a %h b %h imm %0d: result %h, expected %h",
                                  $past(op), $past(operands.a), $past(operands.b),
                                  $past(imm), result, $past(modelNow.result)));

  flagMatches : assert property (@(posedge clk)
      historyValid && $past(rstN) |-> overflow == $past(modelNow.overflow))
    else reportMismatch($sformatf("op %b a %h b %h: overflow %b, expected %b",
                                  $past(op), $past(operands.a), $past(operands.b),
                                  overflow, $past(modelNow.overflow)));

  // one operation per cycle, applied just after the edge
  task automatic issue(input aluPkg::aluOp_t opIn, input aluPkg::word_t aIn,
                       input aluPkg::word_t bIn, input aluPkg::shamt_t immIn);
    @(posedge clk);
    op         <= opIn;
    operands.a <= aIn;
    operands.b <= bIn;
    imm        <= immIn;
    issuedOps  = issuedOps + 1;
  endtask

  // mostly uniform, sometimes a limit value
  function automatic aluPkg::word_t randomWord();
    aluPkg::word_t w;
    case ($urandom_range(7, 0))
      0: w = 16'h7FFF;
      1: w = 16'h8000;
      2: w = 16'hFFFF;
      3: w = 16'h7777 ^ 16'($urandom_range(3, 0));
      default: w = 16'($urandom);
    endcase
    return w;
  endfunction

  initial begin
    aluPkg::word_t data [2];
    logic [3:0]    code;
    int unsigned   waited;

    void'($urandom(32'h8f41));
    clk           = 1'b0;
    rstN          = 1'b0;
    operands      = '0;
    imm           = '0;
    op            = aluPkg::opAdd;
    historyValid  = 1'b0;
    prevRstN      = 1'b0;
    checkedCycles = 0;
    issuedOps     = 0;

    repeat (10) @(posedge clk);
    rstN <= 1'b1;

    // saturating add and subtract
    issue(aluPkg::opAdd, 16'h7FFF, 16'h0001, 4'd0);
    issue(aluPkg::opSub, 16'h8000, 16'h0001, 4'd0);
    issue(aluPkg::opAdd, 16'h8000, 16'h8000, 4'd0);
    issue(aluPkg::opAdd, 16'h8000, 16'hFFFF, 4'd0);
    issue(aluPkg::opSub, 16'h7FFF, 16'hFFFF, 4'd0);
    issue(aluPkg::opSub, 16'h0000, 16'h8000, 4'd0);
    issue(aluPkg::opSub, 16'hFFFF, 16'h8000, 4'd0);
    issue(aluPkg::opAdd, 16'h7FFE, 16'h0001, 4'd0);  // lands on the limit, no flag
    issue(aluPkg::opSub, 16'h8001, 16'h0001, 4'd0);
    issue(aluPkg::opAdd, 16'h1234, 16'hEDCC, 4'd0);

    // nibble lanes
    issue(aluPkg::opPaddsb, 16'h7777, 16'h1111, 4'd0);
    issue(aluPkg::opPaddsb, 16'h8888, 16'h8888, 4'd0);
    issue(aluPkg::opPaddsb, 16'h7F80, 16'h1F8F, 4'd0);
    issue(aluPkg::opPaddsb, 16'h1234, 16'h4321, 4'd0);

    // byte reduction extremes
    issue(aluPkg::opRed, 16'h8080, 16'h8080, 4'd0);
    issue(aluPkg::opRed, 16'h7F7F, 16'h7F7F, 4'd0);
    issue(aluPkg::opRed, 16'h80FF, 16'h7F01, 4'd0);

    // every shift amount, negative and positive data
    data[0] = 16'h8D35;
    data[1] = 16'h4B6A;
    for (int d = 0; d < 2; d++) begin
      for (int s = 0; s < 16; s++) begin
        issue(aluPkg::opSll, data[d], randomWord(), 4'(s));
        issue(aluPkg::opSra, data[d], randomWord(), 4'(s));
        issue(aluPkg::opRor, data[d], randomWord(), 4'(s));
      end
    end

    // xor and the unused opcodes
    issue(aluPkg::opXor, 16'hFFFF, 16'h8000, 4'd3);
    issue(aluPkg::opXor, randomWord(), randomWord(), 4'd0);
    for (int c = 8; c < 16; c++) begin
      code = 4'(c);
      issue(aluPkg::aluOp_t'(code), randomWord(), randomWord(), 4'($urandom));
    end

    // random mix over all sixteen opcodes
    for (int n = 0; n < 400; n++) begin
      code = 4'($urandom_range(15, 0));
      issue(aluPkg::aluOp_t'(code), randomWord(), randomWord(), 4'($urandom));
    end

    issue(aluPkg::opXor, 16'h0000, 16'h0000, 4'd0);  // idle

    // let the last operations reach the checks
    waited = 0;
    while (checkedCycles < issuedOps + 2 && waited < 20) begin
      @(posedge clk);
      waited = waited + 1;
    end
    if (checkedCycles < issuedOps + 2) begin
      $display("timeout: the last results were never compared");
      stopWithFailure();
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: alu.f
source/aluPkg.sv
source/claAdder4.sv
source/satAddSub.sv
source/nibbleSatAdder.sv
source/byteReducer.sv
source/shifter.sv
source/alu.sv
tests/aluTb.sv
